//--- pio_pkg.sv
package pio_pkg;

  localparam int DATA_W = 32;
  localparam int PC_W   = 5;
  localparam int DIV_W  = 16;

  typedef enum logic [2:0] {
    OP_JMP      = 3'd0,
    OP_WAIT     = 3'd1,
    OP_IN       = 3'd2,
    OP_OUT      = 3'd3,
    OP_PUSHPULL = 3'd4,  // op1[2] selects PULL
    OP_MOV      = 3'd5,
    OP_IRQ      = 3'd6,  // Executes as a no-op
    OP_SET      = 3'd7
  } op_e;

  // IN and MOV sources
  localparam logic [2:0] SRC_PINS = 3'd0;
  localparam logic [2:0] SRC_X    = 3'd1;
  localparam logic [2:0] SRC_Y    = 3'd2;
  localparam logic [2:0] SRC_NULL = 3'd3;
  localparam logic [2:0] SRC_ISR  = 3'd6;
  localparam logic [2:0] SRC_OSR  = 3'd7;

  // OUT, MOV and SET destinations
  localparam logic [2:0] DST_PINS    = 3'd0;
  localparam logic [2:0] DST_X       = 3'd1;
  localparam logic [2:0] DST_Y       = 3'd2;
  localparam logic [2:0] DST_PINDIRS = 3'd4;
  localparam logic [2:0] DST_PC      = 3'd5;
  localparam logic [2:0] DST_ISR     = 3'd6;
  localparam logic [2:0] DST_OSR     = 3'd7;

  localparam logic [1:0] MOVOP_NONE    = 2'd0;
  localparam logic [1:0] MOVOP_INVERT  = 2'd1;
  localparam logic [1:0] MOVOP_REVERSE = 2'd2;

endpackage

//--- clk_divider.sv
`timescale 1ns/10ps
module clk_divider import pio_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             en,
  input  logic [DIV_W-1:0] div,
  output logic             tick
);

  logic [DIV_W-1:0] cnt;
  logic [DIV_W-1:0] last;

  assign last = (div > 1) ? div - 1'b1 : '0;  // 0 and 1 both tick every cycle
  assign tick = en && (cnt == last);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!en || tick) begin
      cnt <= '0;  // Restart the period
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- instr_decoder.sv
`timescale 1ns/10ps
module instr_decoder import pio_pkg::*; (
  input  logic [15:0] instr,
  output op_e         op,
  output logic [2:0]  op1,
  output logic [4:0]  op2,
  output logic [4:0]  delay
);

  // No side-set, so the whole 5-bit field is delay
  assign op    = op_e'(instr[15:13]);
  assign delay = instr[12:8];
  assign op1   = instr[7:5];   // Condition, source or destination
  assign op2   = instr[4:0];   // Address, bit count, index or data

endmodule

//--- pc_reg.sv
`timescale 1ns/10ps
module pc_reg import pio_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            exec,
  input  logic            stall,
  input  logic            jmp,
  input  logic [PC_W-1:0] target,
  input  logic [PC_W-1:0] wrap_target,
  input  logic [PC_W-1:0] wrap_top,
  output logic [PC_W-1:0] pc
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (exec && !stall) begin
      if (jmp) begin
        pc <= target;
      end else if (pc == wrap_top) begin
        pc <= wrap_target;  // Program wrap
      end else begin
        pc <= pc + 1'b1;
      end
    end
  end

endmodule

//--- scratch_reg.sv
`timescale 1ns/10ps
module scratch_reg import pio_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              exec,
  input  logic              load,
  input  logic              dec,
  input  logic [DATA_W-1:0] din,
  output logic [DATA_W-1:0] dout
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dout <= '0;
    end else if (exec) begin
      if (load) begin
        dout <= din;
      end else if (dec) begin
        dout <= dout - 1'b1;  // Wraps below zero
      end
    end
  end

endmodule

//--- shift_in_reg.sv
`timescale 1ns/10ps
module shift_in_reg import pio_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              exec,
  input  logic              shift_right,
  input  logic              shift,
  input  logic              load,
  input  logic [4:0]        bit_count,
  input  logic [DATA_W-1:0] din,
  output logic [DATA_W-1:0] dout,
  output logic [5:0]        shift_count
);

  logic [5:0]          n;
  logic [2*DATA_W-1:0] wide;
  logic [DATA_W-1:0]   next;
  logic [6:0]          sum;

  assign n = (bit_count == '0) ? 6'd32 : {1'b0, bit_count};

  // New bits enter at the top when shifting right, at the bottom otherwise
  always_comb begin
    if (shift_right) begin
      wide = {din, dout} >> n;
      next = wide[DATA_W-1:0];
    end else begin
      wide = {dout, din << (6'd32 - n)} << n;
      next = wide[2*DATA_W-1:DATA_W];
    end
  end

  assign sum = shift_count + n;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dout        <= '0;
      shift_count <= '0;
    end else if (exec) begin
      if (load) begin
        dout        <= din;
        shift_count <= '0;
      end else if (shift) begin
        dout        <= next;
        shift_count <= (sum > 7'd32) ? 6'd32 : sum[5:0];  // Saturate at full
      end
    end
  end

endmodule

//--- shift_out_reg.sv
`timescale 1ns/10ps
module shift_out_reg import pio_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              exec,
  input  logic              shift_right,
  input  logic              shift,
  input  logic              load,
  input  logic [4:0]        bit_count,
  input  logic [DATA_W-1:0] din,
  output logic [DATA_W-1:0] dout,
  output logic [DATA_W-1:0] shifted,
  output logic [5:0]        shift_count
);

  logic [5:0] n;
  logic [6:0] sum;

  assign n = (bit_count == '0) ? 6'd32 : {1'b0, bit_count};

  // Bits about to leave, right aligned
  always_comb begin
    if (shift_right) begin
      shifted = dout & ~({DATA_W{1'b1}} << n);  // Low n bits
    end else begin
      shifted = dout >> (6'd32 - n);            // High n bits
    end
  end

  assign sum = shift_count + n;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dout        <= '0;
      shift_count <= 6'd32;  // Empty
    end else if (exec) begin
      if (load) begin
        dout        <= din;
        shift_count <= '0;
      end else if (shift) begin
        dout        <= shift_right ? dout >> n : dout << n;
        shift_count <= (sum > 7'd32) ? 6'd32 : sum[5:0];
      end
    end
  end

endmodule

//--- sm_control.sv
`timescale 1ns/10ps
module sm_control import pio_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              en,
  input  logic              tick,
  input  op_e               op,
  input  logic [2:0]        op1,
  input  logic [4:0]        op2,
  input  logic [4:0]        delay,
  input  logic [DATA_W-1:0] x,
  input  logic [DATA_W-1:0] y,
  input  logic [DATA_W-1:0] isr,
  input  logic [DATA_W-1:0] osr,
  input  logic [DATA_W-1:0] osr_shifted,
  input  logic [5:0]        osr_count,
  input  logic [DATA_W-1:0] gpio_in,
  input  logic [4:0]        jmp_pin,
  input  logic [4:0]        in_base,
  input  logic [4:0]        out_base,
  input  logic [5:0]        out_count,
  input  logic [4:0]        set_base,
  input  logic [2:0]        set_count,
  input  logic [DATA_W-1:0] din,
  input  logic              empty,
  input  logic              full,
  output logic              exec,
  output logic              stall,
  output logic              jmp,
  output logic [DATA_W-1:0] new_val,
  output logic              load_x,
  output logic              dec_x,
  output logic              load_y,
  output logic              dec_y,
  output logic              isr_load,
  output logic              isr_shift,
  output logic              osr_load,
  output logic              osr_shift,
  output logic [4:0]        bit_count,
  output logic              pull,
  output logic              push,
  output logic [DATA_W-1:0] dout,
  output logic [DATA_W-1:0] gpio_out,
  output logic [DATA_W-1:0] gpio_oe
);

  logic [4:0]        delay_cnt;
  logic              wait_cond;
  logic              wait_lvl;
  logic [2:0]        src_code;
  logic [DATA_W-1:0] src_data;
  logic [DATA_W-1:0] mov_data;
  logic [DATA_W-1:0] in_pins;
  logic              pins_wr;
  logic              dirs_wr;
  logic [DATA_W-1:0] pin_val;
  logic [4:0]        pin_base;
  logic [DATA_W-1:0] pin_mask;
  logic [DATA_W-1:0] wr_mask;
  logic [DATA_W-1:0] wr_bits;

  function automatic logic [DATA_W-1:0] rotl(input logic [DATA_W-1:0] v, input logic [4:0] s);
    return (v << s) | (v >> (6'd32 - {1'b0, s}));
  endfunction

  assign in_pins = rotl(gpio_in, 5'd0 - in_base);  // in_base becomes bit 0
  assign dout    = isr;

  // Stall conditions
  always_comb begin
    wait_lvl  = 1'b1;
    wait_cond = 1'b0;
    case (op)
      OP_WAIT: begin
        case (op1[1:0])
          2'd0:    wait_lvl = gpio_in[op2];
          2'd1:    wait_lvl = gpio_in[in_base + op2];
          default: wait_lvl = op1[2];  // IRQ source treated as met
        endcase
        wait_cond = (wait_lvl != op1[2]);
      end
      OP_PUSHPULL: wait_cond = op1[2] ? empty : full;
      default: wait_cond = 1'b0;
    endcase
  end

  assign exec  = en && tick && (delay_cnt == '0);
  assign stall = exec && wait_cond;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      delay_cnt <= '0;
    end else if (en && tick) begin
      if (delay_cnt != '0) begin
        delay_cnt <= delay_cnt - 1'b1;
      end else if (!stall) begin
        delay_cnt <= delay;  // Delay starts once the instruction completes
      end
    end
  end

  // Source mux shared by IN and MOV
  always_comb begin
    src_code = (op == OP_MOV) ? op2[2:0] : op1;
    case (src_code)
      SRC_PINS: src_data = in_pins;
      SRC_X:    src_data = x;
      SRC_Y:    src_data = y;
      SRC_NULL: src_data = '0;
      SRC_ISR:  src_data = isr;
      SRC_OSR:  src_data = osr;
      default:  src_data = '0;
    endcase
    case (op2[4:3])
      MOVOP_NONE:    mov_data = src_data;
      MOVOP_INVERT:  mov_data = ~src_data;
      MOVOP_REVERSE: mov_data = {<<{src_data}};
      default:       mov_data = src_data;
    endcase
  end

  always_comb begin
    jmp       = 1'b0;
    new_val   = '0;
    load_x    = 1'b0;
    dec_x     = 1'b0;
    load_y    = 1'b0;
    dec_y     = 1'b0;
    isr_load  = 1'b0;
    isr_shift = 1'b0;
    osr_load  = 1'b0;
    osr_shift = 1'b0;
    bit_count = op2;
    pull      = 1'b0;
    push      = 1'b0;
    pins_wr   = 1'b0;
    dirs_wr   = 1'b0;
    pin_val   = '0;
    pin_base  = out_base;
    pin_mask  = (out_count >= 6'd32) ? '1 : ~({DATA_W{1'b1}} << out_count);
    if (exec && !stall) begin
      case (op)
        OP_JMP: begin
          new_val = {27'b0, op2};
          case (op1)
            3'd0: jmp = 1'b1;
            3'd1: jmp = (x == '0);
            3'd2: begin jmp = (x != '0); dec_x = 1'b1; end  // Test before decrement
            3'd3: jmp = (y == '0);
            3'd4: begin jmp = (y != '0); dec_y = 1'b1; end
            3'd5: jmp = (x != y);
            3'd6: jmp = gpio_in[jmp_pin];
            default: jmp = (osr_count < 6'd32);  // OSR not empty
          endcase
        end
        OP_IN: begin
          isr_shift = 1'b1;
          new_val   = src_data;
        end
        OP_PUSHPULL: begin
          if (op1[2]) begin
            pull     = 1'b1;
            osr_load = 1'b1;
            new_val  = din;
          end else begin
            push     = 1'b1;
            isr_load = 1'b1;  // Clear ISR after push
          end
        end
        OP_SET: begin
          new_val  = {27'b0, op2};
          pin_val  = new_val;
          pin_base = set_base;
          pin_mask = ~({DATA_W{1'b1}} << set_count);
          case (op1)
            DST_PINS:    pins_wr = 1'b1;
            DST_X:       load_x  = 1'b1;
            DST_Y:       load_y  = 1'b1;
            DST_PINDIRS: dirs_wr = 1'b1;
            default: ;
          endcase
        end
        OP_OUT, OP_MOV: begin
          osr_shift = (op == OP_OUT);
          new_val   = (op == OP_OUT) ? osr_shifted : mov_data;
          pin_val   = new_val;
          case (op1)
            DST_PINS:    pins_wr  = 1'b1;
            DST_X:       load_x   = 1'b1;
            DST_Y:       load_y   = 1'b1;
            DST_PINDIRS: dirs_wr  = (op == OP_OUT);
            DST_PC:      jmp      = 1'b1;
            DST_ISR:     isr_load = 1'b1;
            DST_OSR:     osr_load = (op == OP_MOV);
            default: ;
          endcase
        end
        default: ;  // WAIT only stalls, IRQ is a no-op
      endcase
    end
  end

  assign wr_mask = rotl(pin_mask, pin_base);  // Pin field wraps modulo 32
  assign wr_bits = rotl(pin_val, pin_base);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gpio_out <= '0;
      gpio_oe  <= '0;
    end else begin
      if (pins_wr) gpio_out <= (gpio_out & ~wr_mask) | (wr_bits & wr_mask);
      if (dirs_wr) gpio_oe  <= (gpio_oe & ~wr_mask) | (wr_bits & wr_mask);
    end
  end

endmodule

//--- pio_sm.sv
`timescale 1ns/10ps
module pio_sm import pio_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              en,
  input  logic [DIV_W-1:0]  div,
  input  logic [15:0]       instr,
  input  logic [DATA_W-1:0] din,
  input  logic              empty,
  input  logic              full,
  input  logic [DATA_W-1:0] gpio_in,
  input  logic [4:0]        jmp_pin,
  input  logic [PC_W-1:0]   wrap_target,
  input  logic [PC_W-1:0]   wrap_top,
  input  logic [4:0]        out_base,
  input  logic [5:0]        out_count,
  input  logic [4:0]        set_base,
  input  logic [2:0]        set_count,
  input  logic [4:0]        in_base,
  input  logic              in_shift_right,
  input  logic              out_shift_right,
  output logic [PC_W-1:0]   pc,
  output logic              pull,
  output logic              push,
  output logic [DATA_W-1:0] dout,
  output logic [DATA_W-1:0] gpio_out,
  output logic [DATA_W-1:0] gpio_oe
);

  logic              tick;
  op_e               op;
  logic [2:0]        op1;
  logic [4:0]        op2;
  logic [4:0]        delay;
  logic              exec;
  logic              stall;
  logic              jmp;
  logic [DATA_W-1:0] new_val;
  logic              load_x, dec_x, load_y, dec_y;
  logic              isr_load, isr_shift, osr_load, osr_shift;
  logic [4:0]        bit_count;
  logic [DATA_W-1:0] x, y, isr, osr, osr_shifted;
  logic [5:0]        osr_count;

  clk_divider u_div (
    .clk(clk), .rst_n(rst_n), .en(en), .div(div), .tick(tick)
  );

  instr_decoder u_dec (
    .instr(instr), .op(op), .op1(op1), .op2(op2), .delay(delay)
  );

  sm_control u_ctl (
    .clk(clk), .rst_n(rst_n), .en(en), .tick(tick),
    .op(op), .op1(op1), .op2(op2), .delay(delay),
    .x(x), .y(y), .isr(isr), .osr(osr),
    .osr_shifted(osr_shifted), .osr_count(osr_count),
    .gpio_in(gpio_in), .jmp_pin(jmp_pin), .in_base(in_base),
    .out_base(out_base), .out_count(out_count),
    .set_base(set_base), .set_count(set_count),
    .din(din), .empty(empty), .full(full),
    .exec(exec), .stall(stall), .jmp(jmp), .new_val(new_val),
    .load_x(load_x), .dec_x(dec_x), .load_y(load_y), .dec_y(dec_y),
    .isr_load(isr_load), .isr_shift(isr_shift),
    .osr_load(osr_load), .osr_shift(osr_shift), .bit_count(bit_count),
    .pull(pull), .push(push), .dout(dout),
    .gpio_out(gpio_out), .gpio_oe(gpio_oe)
  );

  pc_reg u_pc (
    .clk(clk), .rst_n(rst_n), .exec(exec), .stall(stall), .jmp(jmp),
    .target(new_val[PC_W-1:0]), .wrap_target(wrap_target),
    .wrap_top(wrap_top), .pc(pc)
  );

  scratch_reg u_x (
    .clk(clk), .rst_n(rst_n), .exec(exec),
    .load(load_x), .dec(dec_x), .din(new_val), .dout(x)
  );

  scratch_reg u_y (
    .clk(clk), .rst_n(rst_n), .exec(exec),
    .load(load_y), .dec(dec_y), .din(new_val), .dout(y)
  );

  // ISR fill level has no reader without autopush
  shift_in_reg u_isr (
    .clk(clk), .rst_n(rst_n), .exec(exec), .shift_right(in_shift_right),
    .shift(isr_shift), .load(isr_load), .bit_count(bit_count),
    .din(new_val), .dout(isr), .shift_count()
  );

  shift_out_reg u_osr (
    .clk(clk), .rst_n(rst_n), .exec(exec), .shift_right(out_shift_right),
    .shift(osr_shift), .load(osr_load), .bit_count(bit_count),
    .din(new_val), .dout(osr), .shifted(osr_shifted), .shift_count(osr_count)
  );

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/10ps
module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial clk = 1'b0;
  always #5 clk = ~clk;  // 10 ns period

  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- pio_sm_chk.sv
`timescale 1ns/10ps
module pio_sm_chk import pio_pkg::*; (
  input logic            clk,
  input logic            rst_n,
  input logic            push,
  input logic            pull,
  input logic            full,
  input logic            empty,
  input logic            stall,
  input logic [PC_W-1:0] pc
);

  push_not_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
    else $error("push while RX FIFO full");
  pull_not_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pull && empty))
    else $error("pull while TX FIFO empty");
  // A stalled instruction is repeated
  pc_hold: assert property (@(posedge clk) disable iff (!rst_n) stall |=> $stable(pc))
    else $error("pc moved during stall");
  push_pulse: assert property (@(posedge clk) disable iff (!rst_n) push |=> !push)
    else $error("push longer than one cycle");
  pull_pulse: assert property (@(posedge clk) disable iff (!rst_n) pull |=> !pull)
    else $error("pull longer than one cycle");

endmodule

bind pio_sm pio_sm_chk chk_i (.*);

//--- pio_sm_tb.sv
`timescale 1ns/10ps
module pio_sm_tb import pio_pkg::*; ();

  logic clk, rst_n, en, empty, full, in_shift_right, out_shift_right;
  logic [DIV_W-1:0] div;
  logic [15:0] instr;
  logic [DATA_W-1:0] din, gpio_in, dout, gpio_out, gpio_oe;
  logic [4:0] jmp_pin, out_base, set_base, in_base;
  logic [5:0] out_count;
  logic [2:0] set_count, rb;
  logic [PC_W-1:0] wrap_target, wrap_top, pc;
  logic pull, push, bp_on, gap_chk;
  logic [15:0] prog [32];
  logic [31:0] lfsr = 32'h504f;
  logic [31:0] tx_q[$], ref_tx[$], exp_q[$];
  logic [31:0] m_x = 0, m_y = 0, m_isr = 0, m_osr = 0, m_out = 0, m_oe = 0;
  int m_ocnt = 32;  // OSR starts empty
  int cyc = 0, last_push = -1, exp_gap = 0;

  tb_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

  pio_sm dut_i (.*);

  assign instr = prog[pc];  // Program memory

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [15:0] ins(op_e op, logic [4:0] dly, logic [2:0] a, logic [4:0] b);
    return {op, dly, a, b};
  endfunction

  function automatic logic [31:0] put_pins(logic [31:0] old, logic [31:0] v, int base, int cnt);
    logic [31:0] r;
    r = old;
    for (int i = 0; i < cnt; i++) r[(base + i) % 32] = v[i];
    return r;
  endfunction

  function automatic logic [31:0] src_val(logic [2:0] code);
    logic [31:0] r;
    r = '0;
    case (code)
      SRC_PINS: for (int i = 0; i < 32; i++) r[i] = gpio_in[(in_base + i) % 32];
      SRC_X:    r = m_x;
      SRC_Y:    r = m_y;
      SRC_ISR:  r = m_isr;
      SRC_OSR:  r = m_osr;
      default:  r = '0;
    endcase
    return r;
  endfunction

  // Interprets the loaded program from address 0 until it reaches 31
  function automatic void ref_run();
    int pc_m, steps, n, tgt;
    logic [15:0] w;
    logic [2:0] a;
    logic [4:0] b;
    logic [31:0] v, r;
    logic t;
    pc_m = 0;
    steps = 0;
    while (pc_m != 31 && steps < 1000) begin
      w = prog[pc_m];
      a = w[7:5];
      b = w[4:0];
      n = (b == 0) ? 32 : b;
      t = 1'b0;
      tgt = b;
      v = '0;
      case (op_e'(w[15:13]))
        OP_JMP: case (a)
          3'd0: t = 1'b1;
          3'd1: t = (m_x == 0);
          3'd2: begin
            t = (m_x != 0);
            m_x = m_x - 1;
          end
          3'd3: t = (m_y == 0);
          3'd4: begin
            t = (m_y != 0);
            m_y = m_y - 1;
          end
          3'd5: t = (m_x != m_y);
          3'd6: t = gpio_in[jmp_pin];
          default: t = (m_ocnt < 32);
        endcase
        OP_IN: begin
          v = src_val(a);
          if (in_shift_right) begin
            for (int i = 0; i < n; i++) m_isr = {v[i], m_isr[31:1]};
          end else begin
            for (int i = n - 1; i >= 0; i--) m_isr = {m_isr[30:0], v[i]};
          end
        end
        OP_OUT: begin
          for (int i = 0; i < n; i++) begin
            if (out_shift_right) begin
              v[i] = m_osr[0];
              m_osr = m_osr >> 1;
            end else begin
              v = {v[30:0], m_osr[31]};
              m_osr = m_osr << 1;
            end
          end
          m_ocnt = (m_ocnt + n > 32) ? 32 : m_ocnt + n;
          case (a)
            DST_PINS:    m_out = put_pins(m_out, v, out_base, out_count);
            DST_X:       m_x = v;
            DST_Y:       m_y = v;
            DST_PINDIRS: m_oe = put_pins(m_oe, v, out_base, out_count);
            DST_PC: begin
              t = 1'b1;
              tgt = v[4:0];
            end
            DST_ISR:     m_isr = v;
            default: ;
          endcase
        end
        OP_PUSHPULL: begin
          if (a[2]) begin
            m_osr = ref_tx.pop_front();
            m_ocnt = 0;
          end else begin
            exp_q.push_back(m_isr);
            m_isr = '0;
          end
        end
        OP_MOV: begin
          v = src_val(b[2:0]);
          if (b[4:3] == MOVOP_INVERT) v = ~v;
          if (b[4:3] == MOVOP_REVERSE) begin
            for (int i = 0; i < 32; i++) r[i] = v[31 - i];
            v = r;
          end
          case (a)
            DST_PINS: m_out = put_pins(m_out, v, out_base, out_count);
            DST_X:    m_x = v;
            DST_Y:    m_y = v;
            DST_PC: begin
              t = 1'b1;
              tgt = v[4:0];
            end
            DST_ISR:  m_isr = v;
            DST_OSR: begin
              m_osr = v;
              m_ocnt = 0;
            end
            default: ;
          endcase
        end
        OP_SET: case (a)
          DST_PINS:    m_out = put_pins(m_out, {27'b0, b}, set_base, set_count);
          DST_X:       m_x = {27'b0, b};
          DST_Y:       m_y = {27'b0, b};
          DST_PINDIRS: m_oe = put_pins(m_oe, {27'b0, b}, set_base, set_count);
          default: ;
        endcase
        default: ;  // Level waits end once the pin matches
      endcase
      pc_m = t ? tgt : ((pc_m == wrap_top) ? wrap_target : pc_m + 1);
      steps++;
    end
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic give_up(input string what);
    $display("Timeout while waiting for %s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  endtask

  task automatic stop_sm();
    @(posedge clk);
    en <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < 32; i++) prog[i] = ins(OP_JMP, 0, 0, 31);  // Halt loop
  endtask

  task automatic start_prog();
    int n;
    @(posedge clk);
    ref_tx = tx_q;
    ref_run();
    last_push = -1;
    prog[31] = ins(OP_JMP, 0, 0, 0);
    en <= 1'b1;
    n = 0;
    @(negedge clk);
    while (pc == 31) begin
      @(negedge clk);
      n++;
      if (n > 200) give_up("program start");
    end
    prog[31] = ins(OP_JMP, 0, 0, 31);
    n = 0;
    while (!(exp_q.size() == 0 && pc == 31)) begin
      @(negedge clk);
      n++;
      if (n > 5000) give_up("program end");
    end
    check_eq(gpio_out, m_out, "gpio_out");
    check_eq(gpio_oe, m_oe, "gpio_oe");
    check_eq(tx_q.size(), 0, "TX words left");
  endtask

  always @(posedge clk) cyc <= cyc + 1;

  // FIFO models and pin noise
  always @(posedge clk) begin
    if (pull) void'(tx_q.pop_front());
    rb = rand_bits(3);
    empty <= (tx_q.size() == 0) || (bp_on && rb[0]);
    din <= (tx_q.size() != 0) ? tx_q[0] : '0;
    full <= bp_on && rb[1];
    if (bp_on) gpio_in[7] <= rb[2];
  end

  always @(posedge clk) begin
    if (rst_n && push) begin
      if (exp_q.size() == 0) begin
        $display("DUT pushed a word that the reference does not expect");
        $display("SIMULATION FAILED");
        $fatal(1, "extra push");
      end else begin
        check_eq(dout, exp_q.pop_front(), "rx word");
        if (gap_chk && last_push >= 0) check_eq(cyc - last_push, exp_gap, "push spacing");
        last_push = cyc;
      end
    end
  end

  initial begin
    int n;
    en = 0;
    div = 1;
    din = 0;
    empty = 1;
    full = 0;
    gpio_in = 0;
    jmp_pin = 0;
    wrap_target = 0;
    wrap_top = 31;
    out_base = 0;
    out_count = 32;
    set_base = 0;
    set_count = 5;
    in_base = 0;
    in_shift_right = 0;
    out_shift_right = 0;
    bp_on = 0;
    gap_chk = 0;
    for (int i = 0; i < 32; i++) prog[i] = ins(OP_JMP, 0, 0, 31);
    n = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      n++;
      if (n > 100) give_up("reset release");
    end
    // SET to pins and pin directions with a wrapping base
    for (int k = 0; k < 2; k++) begin
      stop_sm();
      set_base <= k ? 5'd9 : 5'd30;
      set_count <= k ? 3'd3 : 3'd5;
      prog[0] = ins(OP_SET, 0, DST_PINS, 21);
      prog[1] = ins(OP_SET, 0, DST_PINDIRS, 31);
      prog[2] = ins(OP_SET, 1, DST_PINS, 10);
      prog[3] = ins(OP_PUSHPULL, 0, 0, 0);
      start_prog();
    end
    // X decrement loop and every JMP condition
    stop_sm();
    jmp_pin <= 5;
    gpio_in <= 32'h20;
    prog[0] = ins(OP_SET, 0, DST_X, 4);
    prog[1] = ins(OP_IN, 0, SRC_X, 0);
    prog[2] = ins(OP_PUSHPULL, 0, 0, 0);
    prog[3] = ins(OP_JMP, 0, 2, 1);
    prog[4] = ins(OP_JMP, 0, 1, 7);
    prog[5] = ins(OP_SET, 0, DST_Y, 7);
    prog[6] = ins(OP_JMP, 0, 5, 8);
    prog[7] = ins(OP_PUSHPULL, 0, 0, 0);  // Reached only on a wrong branch
    prog[8] = ins(OP_JMP, 0, 6, 10);
    prog[9] = ins(OP_PUSHPULL, 0, 0, 0);
    prog[10] = ins(OP_JMP, 0, 7, 12);
    prog[11] = ins(OP_SET, 0, DST_Y, 2);
    prog[12] = ins(OP_JMP, 0, 4, 14);
    prog[13] = ins(OP_PUSHPULL, 0, 0, 0);
    prog[14] = ins(OP_JMP, 0, 3, 16);
    prog[15] = ins(OP_IN, 0, SRC_Y, 0);
    prog[16] = ins(OP_IN, 0, SRC_X, 16);
    prog[17] = ins(OP_PUSHPULL, 0, 0, 0);
    start_prog();
    // OUT and IN in both shift directions
    for (int k = 0; k < 2; k++) begin
      stop_sm();
      in_shift_right <= k[0];
      out_shift_right <= k[0];
      out_base <= 4;
      out_count <= 8;
      in_base <= 3;
      gpio_in <= rand_bits(32);
      tx_q.push_back(rand_bits(32));
      prog[0] = ins(OP_PUSHPULL, 0, 3'b100, 0);
      prog[1] = ins(OP_OUT, 0, DST_PINS, 8);
      prog[2] = ins(OP_OUT, 0, DST_X, 12);
      prog[3] = ins(OP_IN, 0, SRC_PINS, 6);
      prog[4] = ins(OP_IN, 0, SRC_X, 10);
      prog[5] = ins(OP_PUSHPULL, 0, 0, 0);
      prog[6] = ins(OP_OUT, 0, DST_PINDIRS, 5);
      start_prog();
    end
    // MOV with none, invert and reverse
    stop_sm();
    tx_q.push_back(rand_bits(32));
    prog[0] = ins(OP_PUSHPULL, 0, 3'b100, 0);
    prog[1] = ins(OP_MOV, 0, DST_X, {MOVOP_INVERT, SRC_OSR});
    prog[2] = ins(OP_MOV, 0, DST_Y, {MOVOP_REVERSE, SRC_X});
    prog[3] = ins(OP_MOV, 0, DST_ISR, {MOVOP_NONE, SRC_Y});
    prog[4] = ins(OP_PUSHPULL, 0, 0, 0);
    prog[5] = ins(OP_MOV, 0, DST_ISR, {MOVOP_NONE, SRC_X});
    prog[6] = ins(OP_PUSHPULL, 0, 0, 0);
    prog[7] = ins(OP_MOV, 0, DST_OSR, {MOVOP_INVERT, SRC_Y});
    prog[8] = ins(OP_MOV, 0, DST_ISR, {MOVOP_REVERSE, SRC_OSR});
    prog[9] = ins(OP_PUSHPULL, 0, 0, 0);
    start_prog();
    // Random back-pressure and a level wait
    stop_sm();
    bp_on <= 1'b1;
    for (int i = 0; i < 6; i++) tx_q.push_back(rand_bits(32));
    prog[0] = ins(OP_SET, 0, DST_X, 5);
    prog[1] = ins(OP_PUSHPULL, 0, 3'b100, 0);
    prog[2] = ins(OP_WAIT, 0, 3'b100, 7);
    prog[3] = ins(OP_MOV, 0, DST_ISR, {MOVOP_NONE, SRC_OSR});
    prog[4] = ins(OP_PUSHPULL, 0, 0, 0);
    prog[5] = ins(OP_JMP, 0, 2, 1);
    start_prog();
    // Divider and delay timing
    stop_sm();
    bp_on <= 1'b0;
    div <= 3;
    gap_chk <= 1'b1;
    exp_gap = 3 * ((1 + 0) + (1 + 2) + (1 + 0));
    prog[0] = ins(OP_SET, 0, DST_Y, 3);
    prog[1] = ins(OP_PUSHPULL, 0, 0, 0);
    prog[2] = ins(OP_SET, 2, DST_X, 1);
    prog[3] = ins(OP_JMP, 0, 4, 1);
    start_prog();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- all.f
pio_pkg.sv
clk_divider.sv
instr_decoder.sv
pc_reg.sv
scratch_reg.sv
shift_in_reg.sv
shift_out_reg.sv
sm_control.sv
pio_sm.sv
tb_clk_gen.sv
pio_sm_chk.sv
pio_sm_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module pio_sm_tb -o sim_pio
out="$(./obj_dir/sim_pio || true)"
echo "$out"
if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi
